//--- Bender.yml
package:
  name: vic

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vic_pkg.sv
      - rtl/vic_ifs.sv
      - rtl/vic_timing.sv
      - rtl/vic_regs.sv
      - rtl/vic_fetch.sv
      - rtl/vic_bus_arbiter.sv
      - rtl/vic_pixel.sv
      - rtl/vic_top.sv
      - target: test
        files:
          - dv/vic_tb.sv

//--- dv/vic_tb.sv
`timescale 1ns/1ps
`include "vic_settings.svh"

module vic_tb;
  import vicPkg::*;

  // 63 phi cycles of 32 ticks per line
  localparam int LINE_CLKS = (`VIC_X_MAX + 1) / 8 * `VIC_TICKS_PER_CYCLE;
  localparam int FRAME_CLKS = (`VIC_Y_MAX + 1) * LINE_CLKS;
  localparam int WATCHDOG_CLKS = 2 * FRAME_CLKS + 20000;
  localparam vicColor EDGE_COLOR = LIGHT_BLUE;
  localparam vicColor BACK_COLOR = BLUE;
  localparam vicColor SCREEN_COLOR = GREEN;
  // video matrix at $0400 and character base at $1000
  localparam logic [3:0] SCREEN_VM = 4'd1;
  localparam logic [2:0] CHAR_CB = 3'd2;

  logic        clk_dot4x;
  logic        rst;
  logic [5:0]  adi;
  logic [11:0] dbi;
  logic        ce;
  logic        rw;
  logic [11:0] dbo;
  logic        irq;
  logic        ba;
  logic        aec;
  logic        phi;
  vicAddr      addr;
  vicColor     pixel;

  logic        cpuDrive;
  logic [11:0] cpuData;
  longint      pos;
  int          errorCount;
  int          checkCount;
  integer      seed;

  vic_top u_dut (.clk_dot4x, .rst, .adi, .dbi, .ce, .rw, .dbo, .irq, .ba, .aec, .phi,
                 .addr, .pixel);

  // ------------------------------------------------------------
  // memory model with screen codes 0 in colour 5 and char 0 all ones
  // ------------------------------------------------------------
  function automatic logic [11:0] memWord(vicAddr a);
    if (a[13:10] == SCREEN_VM) return 12'h500;
    if (a[13:11] == CHAR_CB) return (a[10:3] == 8'h00) ? 12'h0FF : 12'h000;
    // everything else gets a pattern of the full address
    return 12'(a) ^ {a[13:12], 10'h000};
  endfunction

  // cpu owns dbi only while it writes
  assign dbi = cpuDrive ? cpuData : memWord(addr);

  initial begin
    clk_dot4x = 1'b0;
    forever #50 clk_dot4x = ~clk_dot4x;
  end

  // clock count since reset follows the raster beam
  always @(posedge clk_dot4x) begin
    if (rst) pos <= 0;
    else     pos <= pos + 1;
  end

  function automatic int lineNow();
    return int'((pos / LINE_CLKS) % (`VIC_Y_MAX + 1));
  endfunction

  function automatic int cycleNow();
    return int'((pos % LINE_CLKS) / `VIC_TICKS_PER_CYCLE);
  endfunction

  function automatic int tickNow();
    return int'(pos % `VIC_TICKS_PER_CYCLE);
  endfunction

  // four ticks per dot
  function automatic int xNow();
    return int'((pos % LINE_CLKS) / 4);
  endfunction

  task automatic step();
    @(posedge clk_dot4x);
    #1;
  endtask

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic checkReg(string name, logic [7:0] expected, logic [7:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkAddr(string name, vicAddr expected, vicAddr actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkColor(string name, vicColor expected, vicColor actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic checkBit(string name, logic expected, logic actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic reportFailure(string what);
    errorCount++;
    $display("ERROR: %s", what);
  endtask

  // ------------------------------------------------------------
  // cpu bus
  // ------------------------------------------------------------
  task automatic regWrite(vicRegAddr a, logic [7:0] value);
    logic granted;
    granted = 1'b0;
    while (!granted) begin
      // start on the first tick of phi high
      while (tickNow() != 16) step();
      adi = a;
      cpuData = {4'h0, value};
      cpuDrive = 1'b1;
      ce = 1'b0;
      rw = 1'b0;
      repeat (7) step();
      // aec as seen by the write strobe on the next edge
      granted = aec;
      step();
      ce = 1'b1;
      rw = 1'b1;
      cpuDrive = 1'b0;
    end
  endtask

  task automatic regRead(vicRegAddr a, output logic [7:0] value);
    adi = a;
    ce = 1'b0;
    rw = 1'b1;
    step();
    value = dbo[7:0];
    ce = 1'b1;
  endtask

  // bit 8 is read on both sides of the low byte and retried if it moved
  task automatic readRasterLine(output int line);
    logic [7:0] hiFirst;
    logic [7:0] lo;
    logic [7:0] hiSecond;
    do begin
      regRead(REG_CTRL1, hiFirst);
      regRead(REG_RASTER, lo);
      regRead(REG_CTRL1, hiSecond);
    end while (hiFirst[7] != hiSecond[7]);
    line = {hiFirst[7], lo};
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  // phi is low for ticks 0 to 15 and high for ticks 16 to 31
  task automatic testPhase();
    repeat (2 * `VIC_TICKS_PER_CYCLE) begin
      checkBit("phi", tickNow() >= 16, phi);
      step();
    end
  endtask

  task automatic testRegisters();
    vicRegAddr colourRegs [5] = '{REG_EC, REG_B0C, REG_B1C, REG_B2C, REG_B3C};
    logic [7:0] value;
    logic [7:0] got;
    logic [8:0] line;
    repeat (4) begin
      foreach (colourRegs[i]) begin
        value = 8'($random(seed));
        regWrite(colourRegs[i], value);
        regRead(colourRegs[i], got);
        checkReg($sformatf("colour reg %h", colourRegs[i]), {4'hF, value[3:0]}, got);
      end
      value = 8'($random(seed));
      regWrite(REG_CTRL2, value);
      regRead(REG_CTRL2, got);
      checkReg("control 2", {3'b111, value[4:0]}, got);
      value = 8'($random(seed));
      regWrite(REG_MEM_SETUP, value);
      regRead(REG_MEM_SETUP, got);
      checkReg("memory setup", {value[7:1], 1'b1}, got);
      value = 8'($random(seed));
      regWrite(REG_IRQ_ENABLE, value);
      regRead(REG_IRQ_ENABLE, got);
      checkReg("irq enable", {7'h7F, value[0]}, got);
      // bit 7 of control 1 reads the raster line rather than the compare
      value = 8'($random(seed));
      regWrite(REG_CTRL1, value);
      line = 9'(lineNow());
      regRead(REG_CTRL1, got);
      checkReg("control 1", {line[8], value[6:0]}, got);
    end
  endtask

  task automatic setupDisplay();
    // den, rsel and yscroll 3
    regWrite(REG_CTRL1, 8'h1B);
    // csel, hires, xscroll 0
    regWrite(REG_CTRL2, 8'h08);
    regWrite(REG_MEM_SETUP, {SCREEN_VM, CHAR_CB, 1'b0});
    regWrite(REG_EC, {4'h0, EDGE_COLOR});
    regWrite(REG_B0C, {4'h0, BACK_COLOR});
    regWrite(REG_IRQ_ENABLE, 8'h00);
    regWrite(REG_IRQ_STATUS, 8'h01);
  endtask

  task automatic testRasterLine();
    int prev;
    int cur;
    int advances;
    advances = 0;
    readRasterLine(prev);
    repeat (40) begin
      repeat (200) step();
      readRasterLine(cur);
      checkCount++;
      if (cur != prev && cur != prev + 1 && !(prev == `VIC_Y_MAX && cur == 0))
        reportFailure($sformatf("raster line jumped from %0d to %0d", prev, cur));
      if (cur != prev) advances++;
      prev = cur;
    end
    // the 40 reads span a little over four lines
    checkCount++;
    if (advances < 3)
      reportFailure($sformatf("raster line advanced only %0d times over four lines", advances));
  endtask

  task automatic testRasterIrq();
    int line;
    int target;
    int waited;
    logic stuck;
    logic [7:0] got;
    // a compare line a few lines ahead of the beam
    readRasterLine(line);
    target = line + 4;
    regWrite(REG_CTRL1, 8'h1B);
    regWrite(REG_RASTER, 8'(target));
    regWrite(REG_IRQ_STATUS, 8'h01);
    regWrite(REG_IRQ_ENABLE, 8'h01);
    waited = 0;
    while (!irq && waited < 8 * LINE_CLKS) begin
      step();
      waited++;
    end
    if (!irq) begin
      reportFailure($sformatf("raster irq never rose for compare line %0d", target));
    end else begin
      regRead(REG_RASTER, got);
      checkReg("raster irq line", 8'(target), got);
    end
    regWrite(REG_IRQ_STATUS, 8'h01);
    checkBit("irq after status write", 1'b0, irq);
    // with the enable clear the status bit still latches
    regWrite(REG_IRQ_ENABLE, 8'h00);
    readRasterLine(line);
    target = line + 2;
    regWrite(REG_RASTER, 8'(target));
    stuck = 1'b0;
    while (lineNow() != target + 1) begin
      step();
      if (irq !== 1'b0) stuck = 1'b1;
    end
    checkCount++;
    if (stuck) reportFailure("irq went high with the raster enable clear");
    regRead(REG_IRQ_STATUS, got);
    checkReg("raster status, enable clear", 8'h7F, got);
    regWrite(REG_IRQ_STATUS, 8'h01);
  endtask

  task automatic testRefresh();
    logic [7:0] prevLow;
    logic have;
    int count;
    have = 1'b0;
    count = 0;
    while (lineNow() != 20) step();
    while (lineNow() != 23) begin
      step();
      // the refresh slot is on the bus in mid phi low
      if (tickNow() == 8 && addr[13:8] == 6'h3F && addr != 14'h3FFF) begin
        if (have) checkAddr("refresh", vicAddr'({6'h3F, 8'(prevLow - 8'd1)}), addr);
        prevLow = addr[7:0];
        have = 1'b1;
        count++;
      end
    end
    if (count != 3 * `VIC_REFRESH_SLOTS)
      reportFailure($sformatf("saw %0d refresh addresses over 3 lines", count));
  endtask

  task automatic testBadline();
    int baHigh;
    int aecHigh;
    int n;
    int cyc;
    baHigh = 0;
    aecHigh = 0;
    n = 0;
    // line 51 is the first badline of the frame with yscroll 3
    while (lineNow() != 51) step();
    while (lineNow() == 51) begin
      cyc = cycleNow();
      if (cyc >= `VIC_BA_FIRST + 1 && cyc <= `VIC_BA_LAST && ba !== 1'b0) baHigh++;
      if (cyc >= `VIC_C_FIRST && cyc <= `VIC_BA_LAST && aec !== 1'b0) aecHigh++;
      if (tickNow() == 24 && addr != 14'h3FFF) begin
        if (n < 40) checkAddr("badline c-access", vicAddr'({SCREEN_VM, 10'(n)}), addr);
        n++;
      end
      step();
    end
    if (baHigh != 0) reportFailure("ba was not held low across the badline window");
    if (aecHigh != 0) reportFailure("aec went high while the VIC held the bus");
    if (n != 40) reportFailure($sformatf("expected 40 c-accesses on line 51, saw %0d", n));
  endtask

  // border is ec and the window must be ec or the inner colour
  task automatic scanPixels(string name, int line, vicColor inner);
    int bad;
    bad = 0;
    while (lineNow() != line) step();
    while (lineNow() == line) begin
      if (pixel !== EDGE_COLOR && pixel !== inner) bad++;
      if (xNow() == 40 && tickNow() % 4 == 0) checkColor({name, " border"}, EDGE_COLOR, pixel);
      if (xNow() == 320 && tickNow() % 4 == 0) checkColor({name, " centre"}, inner, pixel);
      step();
    end
    if (bad != 0) reportFailure($sformatf("%s: %0d clocks with an unexpected colour", name, bad));
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    seed = 14625;
    errorCount = 0;
    checkCount = 0;
    rst = 1'b1;
    ce = 1'b1;
    rw = 1'b1;
    adi = '0;
    cpuDrive = 1'b0;
    cpuData = '0;
    repeat (10) @(posedge clk_dot4x);
    #1;
    rst = 1'b0;
    testPhase();
    testRegisters();
    setupDisplay();
    testRasterLine();
    scanPixels("border line", 10, EDGE_COLOR);
    testRasterIrq();
    testRefresh();
    testBadline();
    scanPixels("text line", 100, SCREEN_COLOR);
    // ecm, bmm and mcm together
    regWrite(REG_CTRL1, 8'h7B);
    regWrite(REG_CTRL2, 8'h18);
    scanPixels("illegal mode", 120, BLACK);
    regWrite(REG_CTRL1, 8'h1B);
    regWrite(REG_CTRL2, 8'h08);
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // two frames plus margin covers the whole sequence
  initial begin
    repeat (WATCHDOG_CLKS) @(posedge clk_dot4x);
    $display("ERROR: watchdog expired after %0d clocks, the run did not finish", WATCHDOG_CLKS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- rtl/vic_bus_arbiter.sv
`timescale 1ns/1ps
`include "vic_settings.svh"

module vic_bus_arbiter (
  input  logic        clk_dot4x,
  input  logic        rst,
  vicBeatIf.sink      beat,
  vicMemIf.arbiter    mem,
  input  logic [11:0] dbi,
  output logic        ba,
  output logic        aec,
  output logic        cpuPhase,
  output vicPkg::vicAddr addr
);
  import vicPkg::*;

  logic [7:0] refc;
  logic       refresh;
  logic       ba1, ba2, ba3;

  assign refresh = !beat.phi && beat.cycleNum >= 7'(`VIC_REFRESH_FIRST) &&
                   beat.cycleNum < 7'(`VIC_REFRESH_FIRST + `VIC_REFRESH_SLOTS);

  // one refresh row per slot, counting down
  always_ff @(posedge clk_dot4x) begin
    if (rst || beat.frameStart) refc <= 8'hFF;
    else if (refresh && beat.tick == 5'd15) refc <= refc - 8'd1;
  end

  // ------------------------------------------------------------
  // ba and the three cycle aec delay
  // ------------------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      ba <= 1'b1;
      ba1 <= 1'b1;
      ba2 <= 1'b1;
      ba3 <= 1'b1;
      aec <= 1'b0;
    end else begin
      ba <= !mem.baReq;
      // sampled once per cycle, at the end of phi high
      if (beat.tick == 5'd31) begin
        ba1 <= ba;
        ba2 <= ba1 | ba;
        ba3 <= ba2 | ba;
      end
      aec <= ba ? beat.phi : (ba3 & beat.phi);
    end
  end

  assign cpuPhase = aec;

  // fetched data goes back on the mem beat
  assign mem.dataStrobe = (beat.tick[3:0] == 4'(`VIC_MEM_DAV)) && (mem.cReq || mem.gReq);
  assign mem.data = dbi;

  always_ff @(posedge clk_dot4x) begin
    if (rst)                       addr <= 14'h3FFF;
    else if (refresh)              addr <= {6'h3F, refc};
    else if (mem.cReq || mem.gReq) addr <= mem.addr;
    else                           addr <= 14'h3FFF;
  end

endmodule

//--- rtl/vic_fetch.sv
`timescale 1ns/1ps
`include "vic_settings.svh"

module vic_fetch (
  input  logic          clk_dot4x,
  input  logic          rst,
  vicBeatIf.sink        beat,
  input  vicPkg::vicCtrl ctrl,
  vicMemIf.requester    mem,
  output logic [7:0]    gData,
  output vicPkg::vicCell gCell,
  output logic          gValid
);
  import vicPkg::*;

  logic       displayEn;
  logic       badline;
  logic [9:0] vcBase;
  logic [9:0] vc;
  logic [2:0] rc;
  logic       idle;
  logic [5:0] bufIdx;
  vicCell     lineBuf [0:39];
  vicCell     curCell;
  vicAddr     gAddr;

  // den only counts on the first display line
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      displayEn <= 1'b0;
    end else if (beat.dotStrobe) begin
      if (beat.rasterLine == 9'(`VIC_DISP_FIRST) && ctrl.den) displayEn <= 1'b1;
      if (beat.rasterLine == 9'(`VIC_DISP_LAST + 1)) displayEn <= 1'b0;
    end
  end

  assign badline = displayEn && beat.rasterLine >= 9'(`VIC_DISP_FIRST) &&
                   beat.rasterLine <= 9'(`VIC_DISP_LAST) &&
                   beat.rasterLine[2:0] == ctrl.yscroll;

  // ------------------------------------------------------------
  // video counter, row counter and idle state
  // ------------------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      vcBase <= '0;
      vc <= '0;
      rc <= '0;
      idle <= 1'b1;
      bufIdx <= '0;
    end else begin
      // start of phi high in the cycle before the first c-access
      if (beat.tick == 5'd16 && beat.cycleNum == 7'(`VIC_C_FIRST - 1)) begin
        vc <= vcBase;
        bufIdx <= '0;
        if (badline) rc <= '0;
      end
      // step after each g-access, cycles 16..55
      if (beat.tick == 5'd15 && beat.cycleNum > 7'(`VIC_C_FIRST) &&
          beat.cycleNum <= 7'(`VIC_C_LAST + 1)) begin
        bufIdx <= bufIdx + 6'd1;
        if (!idle) vc <= vc + 10'd1;
      end
      if (beat.tick == 5'd16 && beat.cycleNum == 7'd58) begin
        if (rc == 3'd7) begin
          vcBase <= vc;
          idle <= 1'b1;
        end else if (!idle || badline) begin
          rc <= rc + 3'd1;
        end
      end
      if (beat.frameStart) vcBase <= '0;
      if (badline) idle <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // requests and addresses
  // ------------------------------------------------------------
  assign mem.baReq = badline && beat.cycleNum >= 7'(`VIC_BA_FIRST) &&
                     beat.cycleNum <= 7'(`VIC_BA_LAST);
  assign mem.cReq = badline && beat.phi && beat.cycleNum >= 7'(`VIC_C_FIRST) &&
                    beat.cycleNum <= 7'(`VIC_C_LAST);
  assign mem.gReq = !beat.phi && beat.cycleNum > 7'(`VIC_C_FIRST) &&
                    beat.cycleNum <= 7'(`VIC_C_LAST + 1);

  assign curCell = idle ? vicCell'(0) : lineBuf[bufIdx];

  always_comb begin
    if (ctrl.bmm) gAddr = {ctrl.cb[2], vc, rc};
    else          gAddr = {ctrl.cb, curCell[7:0], rc};
    // ecm pulls the address into the first 64 characters
    if (ctrl.ecm) gAddr[10:9] = 2'b00;
    if (idle)     gAddr = 14'h3FFF;
  end

  assign mem.addr = mem.cReq ? {ctrl.vm, vc} : (mem.gReq ? gAddr : 14'h3FFF);

  // line buffer fills only on badlines, and is replayed on the other 7 rows
  always_ff @(posedge clk_dot4x) begin
    if (mem.dataStrobe && mem.cReq) lineBuf[bufIdx] <= mem.data;
  end

  always_ff @(posedge clk_dot4x) begin
    if (mem.dataStrobe && mem.gReq) begin
      gData <= mem.data[7:0];
      gCell <= curCell;
    end
  end

  always_ff @(posedge clk_dot4x) begin
    if (rst) gValid <= 1'b0;
    else     gValid <= mem.dataStrobe && mem.gReq;
  end

endmodule

//--- rtl/vic_ifs.sv
`timescale 1ns/1ps

// beat of the raster, fanned out from the sequencer
interface vicBeatIf;
  logic [4:0] tick;
  logic       phi;
  logic       dotStrobe;
  logic [9:0] rasterX;
  logic [8:0] rasterLine;
  logic [6:0] cycleNum;
  logic       frameStart;

  modport source (output tick, phi, dotStrobe, rasterX, rasterLine, cycleNum, frameStart);
  modport sink (input tick, phi, dotStrobe, rasterX, rasterLine, cycleNum, frameStart);
endinterface

// video fetch side of the dram address bus
interface vicMemIf;
  logic           baReq;
  logic           cReq;
  logic           gReq;
  vicPkg::vicAddr addr;
  logic           dataStrobe;
  logic [11:0]    data;

  // fetcher asks, arbiter grants and hands back dbi
  modport requester (
    output baReq, cReq, gReq, addr,
    input  dataStrobe, data
  );
  modport arbiter (
    input  baReq, cReq, gReq, addr,
    output dataStrobe, data
  );
endinterface

//--- rtl/vic_pixel.sv
`timescale 1ns/1ps
`include "vic_settings.svh"

module vic_pixel (
  input  logic              clk_dot4x,
  input  logic              rst,
  vicBeatIf.sink            beat,
  input  vicPkg::vicCtrl    ctrl,
  input  vicPkg::vicPalette palette,
  input  logic [7:0]        gData,
  input  vicPkg::vicCell    gCell,
  input  logic              gValid,
  output vicPkg::vicColor   pixel
);
  import vicPkg::*;

  logic [7:0] waitPixels, shiftPixels;
  vicCell     waitCell, shiftCell;
  logic       loadPixels, ismc, clkShift, border;
  vicColor    color;

  always_ff @(posedge clk_dot4x) begin
    if (gValid) begin
      waitPixels <= gData;
      waitCell <= gCell;
    end
  end

  assign loadPixels = (beat.rasterX[2:0] == ctrl.xscroll);
  assign ismc = ctrl.mcm & (ctrl.bmm | ctrl.ecm | shiftCell[11]);

  // ------------------------------------------------------------
  // shifter, two bits every other dot in multicolour
  // ------------------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (beat.dotStrobe) begin
      if (loadPixels) begin
        shiftPixels <= waitPixels;
        shiftCell <= waitCell;
        clkShift <= ~(ctrl.mcm & (ctrl.bmm | ctrl.ecm | waitCell[11]));
      end else begin
        if (ismc) clkShift <= ~clkShift;
        if (clkShift) begin
          if (ismc) shiftPixels <= {shiftPixels[5:0], 2'b00};
          else      shiftPixels <= {shiftPixels[6:0], 1'b0};
        end
      end
    end
  end

  always_comb begin
    color = BLACK;
    case (vicMode'({ctrl.ecm, ctrl.bmm, ctrl.mcm}))
      MODE_STD_CHAR: color = shiftPixels[7] ? vicColor'(shiftCell[11:8]) : palette.b0c;
      MODE_MC_CHAR:
        if (!shiftCell[11]) color = shiftPixels[7] ? vicColor'(shiftCell[11:8]) : palette.b0c;
        else case (shiftPixels[7:6])
          2'b00: color = palette.b0c;
          2'b01: color = palette.b1c;
          2'b10: color = palette.b2c;
          default: color = vicColor'({1'b0, shiftCell[10:8]});
        endcase
      MODE_STD_BMP: color = shiftPixels[7] ? vicColor'(shiftCell[7:4]) : vicColor'(shiftCell[3:0]);
      MODE_MC_BMP:
        case (shiftPixels[7:6])
          2'b00: color = palette.b0c;
          2'b01: color = vicColor'(shiftCell[7:4]);
          2'b10: color = vicColor'(shiftCell[3:0]);
          default: color = vicColor'(shiftCell[11:8]);
        endcase
      MODE_ECM_CHAR:
        // background picked by the top two code bits
        case ({shiftPixels[7], shiftCell[7:6]})
          3'b000: color = palette.b0c;
          3'b001: color = palette.b1c;
          3'b010: color = palette.b2c;
          3'b011: color = palette.b3c;
          default: color = vicColor'(shiftCell[11:8]);
        endcase
      // the three illegal modes stay black
      default: color = BLACK;
    endcase
  end

  assign border = beat.rasterLine < 9'(`VIC_BORDER_TOP) ||
                  beat.rasterLine >= 9'(`VIC_BORDER_BOTTOM) ||
                  beat.rasterX < 10'(`VIC_BORDER_LEFT) ||
                  beat.rasterX >= 10'(`VIC_BORDER_RIGHT);

  always_ff @(posedge clk_dot4x) begin
    if (rst)                 pixel <= BLACK;
    else if (beat.dotStrobe) pixel <= border ? palette.ec : color;
  end

endmodule

//--- rtl/vic_pkg.sv
package vicPkg;

  // colour index as used by the palette
  typedef enum logic [3:0] {
    BLACK, WHITE, RED, CYAN, PURPLE, GREEN, BLUE, YELLOW,
    ORANGE, BROWN, PINK, DARK_GREY, GREY, LIGHT_GREEN, LIGHT_BLUE, LIGHT_GREY
  } vicColor;

  // cpu register offsets that are kept
  typedef enum logic [5:0] {
    REG_CTRL1      = 6'h11,
    REG_RASTER     = 6'h12,
    REG_CTRL2      = 6'h16,
    REG_MEM_SETUP  = 6'h18,
    REG_IRQ_STATUS = 6'h19,
    REG_IRQ_ENABLE = 6'h1A,
    REG_EC         = 6'h20,
    REG_B0C        = 6'h21,
    REG_B1C        = 6'h22,
    REG_B2C        = 6'h23,
    REG_B3C        = 6'h24
  } vicRegAddr;

  typedef struct packed {
    logic [2:0] yscroll;
    logic [2:0] xscroll;
    logic       rsel;
    logic       csel;
    logic       den;
    logic       bmm;
    logic       ecm;
    logic       mcm;
    logic [3:0] vm;
    logic [2:0] cb;
  } vicCtrl;

  typedef struct packed {
    vicColor ec;
    vicColor b0c;
    vicColor b1c;
    vicColor b2c;
    vicColor b3c;
  } vicPalette;

  typedef logic [13:0] vicAddr;

  // colour nibble on top, screen code below
  typedef logic [11:0] vicCell;

  // order is {ecm, bmm, mcm}
  typedef enum logic [2:0] {
    MODE_STD_CHAR, MODE_MC_CHAR, MODE_STD_BMP, MODE_MC_BMP,
    MODE_ECM_CHAR, MODE_BAD_MC_CHAR, MODE_BAD_STD_BMP, MODE_BAD_MC_BMP
  } vicMode;

endpackage

//--- rtl/vic_regs.sv
`timescale 1ns/1ps
`include "vic_settings.svh"

module vic_regs (
  input  logic        clk_dot4x,
  input  logic        rst,
  vicBeatIf.sink      beat,
  input  logic [5:0]  adi,
  input  logic [11:0] dbi,
  input  logic        ce,
  input  logic        rw,
  input  logic        cpuPhase,
  output logic [11:0] dbo,
  output logic        irq,
  output vicPkg::vicCtrl    ctrl,
  output vicPkg::vicPalette palette
);
  import vicPkg::*;

  logic [8:0] rasterCmp;
  logic       irst;
  logic       erst;
  logic       regWrite;

  // cpu write strobe, one tick inside phi high
  assign regWrite = !ce && !rw && cpuPhase && beat.phi &&
                    beat.tick == 5'(16 + `VIC_REG_DAV);

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      ctrl <= '0;
      ctrl.yscroll <= 3'd3;
      ctrl.den <= 1'b1;
      palette <= {5{BLACK}};
      rasterCmp <= '0;
      erst <= 1'b0;
      irst <= 1'b0;
    end else begin
      // raster match is seen once, on the first dot of the line
      if (beat.dotStrobe && beat.rasterX == '0 && beat.rasterLine == rasterCmp) begin
        irst <= 1'b1;
      end
      if (regWrite) begin
        case (vicRegAddr'(adi))
          REG_CTRL1: begin
            ctrl.yscroll <= dbi[2:0];
            ctrl.rsel <= dbi[3];
            ctrl.den <= dbi[4];
            ctrl.bmm <= dbi[5];
            ctrl.ecm <= dbi[6];
            rasterCmp[8] <= dbi[7];
          end
          REG_RASTER: rasterCmp[7:0] <= dbi[7:0];
          REG_CTRL2: begin
            ctrl.xscroll <= dbi[2:0];
            ctrl.csel <= dbi[3];
            ctrl.mcm <= dbi[4];
          end
          REG_MEM_SETUP: begin
            ctrl.cb <= dbi[3:1];
            ctrl.vm <= dbi[7:4];
          end
          // writing a 1 acknowledges
          REG_IRQ_STATUS: if (dbi[0]) irst <= 1'b0;
          REG_IRQ_ENABLE: erst <= dbi[0];
          REG_EC:  palette.ec <= vicColor'(dbi[3:0]);
          REG_B0C: palette.b0c <= vicColor'(dbi[3:0]);
          REG_B1C: palette.b1c <= vicColor'(dbi[3:0]);
          REG_B2C: palette.b2c <= vicColor'(dbi[3:0]);
          REG_B3C: palette.b3c <= vicColor'(dbi[3:0]);
          default: ;
        endcase
      end
    end
  end

  assign irq = irst & erst;

  // ------------------------------------------------------------
  // read mux, unused bits return 1
  // ------------------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (!ce) begin
      dbo <= 12'hFFF;
      case (vicRegAddr'(adi))
        REG_CTRL1: dbo[7:0] <= {beat.rasterLine[8], ctrl.ecm, ctrl.bmm, ctrl.den,
                                ctrl.rsel, ctrl.yscroll};
        REG_RASTER: dbo[7:0] <= beat.rasterLine[7:0];
        REG_CTRL2: dbo[7:0] <= {3'b111, ctrl.mcm, ctrl.csel, ctrl.xscroll};
        REG_MEM_SETUP: dbo[7:0] <= {ctrl.vm, ctrl.cb, 1'b1};
        // sprite and light-pen sources are gone, their bits read 1
        REG_IRQ_STATUS: dbo[7:0] <= {irq, 6'b111111, irst};
        REG_IRQ_ENABLE: dbo[7:0] <= {7'b1111111, erst};
        REG_EC:  dbo[7:0] <= {4'hF, palette.ec};
        REG_B0C: dbo[7:0] <= {4'hF, palette.b0c};
        REG_B1C: dbo[7:0] <= {4'hF, palette.b1c};
        REG_B2C: dbo[7:0] <= {4'hF, palette.b2c};
        REG_B3C: dbo[7:0] <= {4'hF, palette.b3c};
        default: ;
      endcase
    end
  end

endmodule

//--- rtl/vic_settings.svh
`ifndef VIC_SETTINGS_SVH
`define VIC_SETTINGS_SVH

// ------------------------------------------------------------
// raster geometry, PAL only
// ------------------------------------------------------------
`define VIC_X_MAX 503
`define VIC_Y_MAX 311
`define VIC_TICKS_PER_CYCLE 32

// tick within a phase where cpu data or fetched data is valid
`define VIC_REG_DAV 7
`define VIC_MEM_DAV 13

// ------------------------------------------------------------
// display window and fetch windows, in lines and cycles
// ------------------------------------------------------------
`define VIC_DISP_FIRST 48
`define VIC_DISP_LAST 247
`define VIC_BA_FIRST 11
`define VIC_BA_LAST 53
`define VIC_C_FIRST 15
`define VIC_C_LAST 54
`define VIC_REFRESH_FIRST 11
`define VIC_REFRESH_SLOTS 5
`define VIC_BORDER_TOP 51
`define VIC_BORDER_BOTTOM 251
`define VIC_BORDER_LEFT 160
`define VIC_BORDER_RIGHT 480

`endif

//--- rtl/vic_timing.sv
`timescale 1ns/1ps
`include "vic_settings.svh"

module vic_timing (
  input  logic clk_dot4x,
  input  logic rst,
  vicBeatIf.source beat,
  output logic phi
);

  logic [4:0] tick;
  logic [9:0] rasterX;
  logic [8:0] rasterLine;
  logic       frameStart;
  logic       dotStrobe;

  // ------------------------------------------------------------
  // phase sequencer
  // ------------------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst || tick == 5'(`VIC_TICKS_PER_CYCLE - 1)) begin
      tick <= '0;
    end else begin
      tick <= tick + 5'd1;
    end
  end

  // low half of the cycle belongs to the vic, high half to the cpu
  assign phi = tick[4];
  assign dotStrobe = (tick[1:0] == 2'd3);

  // ------------------------------------------------------------
  // raster position
  // ------------------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterX <= '0;
      rasterLine <= '0;
      frameStart <= 1'b0;
    end else begin
      frameStart <= 1'b0;
      if (dotStrobe) begin
        if (rasterX == 10'(`VIC_X_MAX)) begin
          rasterX <= '0;
          if (rasterLine == 9'(`VIC_Y_MAX)) begin
            rasterLine <= '0;
            frameStart <= 1'b1;
          end else begin
            rasterLine <= rasterLine + 9'd1;
          end
        end else begin
          rasterX <= rasterX + 10'd1;
        end
      end
    end
  end

  assign beat.tick = tick;
  assign beat.phi = phi;
  assign beat.dotStrobe = dotStrobe;
  assign beat.rasterX = rasterX;
  assign beat.rasterLine = rasterLine;
  // eight dots per phi cycle
  assign beat.cycleNum = rasterX[9:3];
  assign beat.frameStart = frameStart;

endmodule

//--- rtl/vic_top.sv
`timescale 1ns/1ps

module vic_top (
  input  logic        clk_dot4x,
  input  logic        rst,
  input  logic [5:0]  adi,
  input  logic [11:0] dbi,
  input  logic        ce,
  input  logic        rw,
  output logic [11:0] dbo,
  output logic        irq,
  output logic        ba,
  output logic        aec,
  output logic        phi,
  output vicPkg::vicAddr  addr,
  output vicPkg::vicColor pixel
);
  import vicPkg::*;

  vicBeatIf beat ();
  vicMemIf  mem ();

  vicCtrl    ctrl;
  vicPalette palette;
  logic      cpuPhase;
  logic [7:0] gData;
  vicCell    gCell;
  logic      gValid;

  // ------------------------------------------------------------
  // timing feeds everyone through the beat
  // ------------------------------------------------------------
  vic_timing u_timing (.clk_dot4x, .rst, .beat(beat.source), .phi);

  vic_regs u_regs (.clk_dot4x, .rst, .beat(beat.sink), .adi, .dbi, .ce, .rw,
                   .cpuPhase, .dbo, .irq, .ctrl, .palette);

  vic_fetch u_fetch (.clk_dot4x, .rst, .beat(beat.sink), .ctrl, .mem(mem.requester),
                     .gData, .gCell, .gValid);

  vic_bus_arbiter u_arbiter (.clk_dot4x, .rst, .beat(beat.sink), .mem(mem.arbiter),
                             .dbi, .ba, .aec, .cpuPhase, .addr);

  vic_pixel u_pixel (.clk_dot4x, .rst, .beat(beat.sink), .ctrl, .palette, .gData,
                     .gCell, .gValid, .pixel);

endmodule

//--- sim.f
+incdir+rtl
rtl/vic_pkg.sv
rtl/vic_ifs.sv
rtl/vic_timing.sv
rtl/vic_regs.sv
rtl/vic_fetch.sv
rtl/vic_bus_arbiter.sv
rtl/vic_pixel.sv
rtl/vic_top.sv
dv/vic_tb.sv
